//--- zynq_core_shell.f
logic/shell_pkg.sv
logic/shell_csr_decode.sv
logic/shell_addr_map.sv
logic/stall_counter_bank.sv
logic/mem_region_profiler.sv
logic/csr_readback.sv
logic/zynq_core_shell.sv
verification/zynq_core_shell_props.sv
verification/tb_zynq_core_shell.sv

//--- Makefile
# Verilator build and run of the zynq_core_shell testbench
TOP := tb_zynq_core_shell
RTL := $(filter logic/%,$(shell cat zynq_core_shell.f))

all: run

build:
	verilator --binary --timing --assert --top-module $(TOP) -f zynq_core_shell.f

# the log decides the verdict, a missing pass line counts as failure
run: build
	./obj_dir/V$(TOP) > sim.log 2>&1; cat sim.log
	@if grep -q "CHECKS FAILED" sim.log; then exit 1; fi
	@grep -q "ALL CHECKS PASSED" sim.log

lint:
	verilator --lint-only -Wall --top-module zynq_core_shell $(RTL)

clean:
	rm -rf obj_dir sim.log

.PHONY: all build run lint clean

//--- verification/tb_zynq_core_shell.sv
`timescale 1ns/1ps

module tb_zynq_core_shell;

   localparam int          clk_period_lp   = 4;
   localparam int          reset_cycles_lp = 3;
   localparam int          num_counters_lp = 8;
   // 241 MiB of PS DRAM handed to the core
   localparam logic [31:0] mem_limit_lp    = 32'(241 * 1024 * 1024);

   localparam int window_tests_lp = 16;
   localparam int dram_tests_lp   = 24;
   localparam int event_cycles_lp = 200;
   // a register access takes three cycles and the run makes fewer than 64 of them
   localparam int watchdog_cycles_lp = reset_cycles_lp + 3 * 64
      + 2 * (window_tests_lp + dram_tests_lp) + event_cycles_lp + 100;

   logic                       aclk;
   logic                       reset;
   logic                       reg_wr;
   logic                       reg_rd;
   logic [7:0]                 reg_addr;
   logic [31:0]                reg_wdata;
   logic [31:0]                reg_rdata;
   logic                       reg_rdata_v;
   logic                       ps_addr_v;
   logic [29:0]                ps_addr;
   logic                       core_addr_v;
   logic [31:0]                core_addr;
   logic                       dram_req_v;
   logic [31:0]                dram_addr;
   logic                       mem_addr_v;
   logic [31:0]                mem_addr;
   logic                       mem_high;
   logic [num_counters_lp-1:0] event_bits;
   logic                       freeze;
   logic                       core_reset;

   // reference model state kept from the register map and counting rules
   logic [15:0]  lfsr_q;
   logic         verdict_printed = 1'b0;
   logic [31:0]  base_model;
   logic [127:0] profile_model;
   logic [63:0]  count_model [num_counters_lp];

   zynq_core_shell #(.num_counters_p(num_counters_lp), .mem_limit_p(mem_limit_lp))
      zynq_core_shell_inst
      (.aclk_i       (aclk)
      ,.reset_i      (reset)
      ,.reg_wr_i     (reg_wr)
      ,.reg_rd_i     (reg_rd)
      ,.reg_addr_i   (reg_addr)
      ,.reg_wdata_i  (reg_wdata)
      ,.reg_rdata_o  (reg_rdata)
      ,.reg_rdata_v_o(reg_rdata_v)
      ,.ps_addr_v_i  (ps_addr_v)
      ,.ps_addr_i    (ps_addr)
      ,.core_addr_v_o(core_addr_v)
      ,.core_addr_o  (core_addr)
      ,.dram_req_v_i (dram_req_v)
      ,.dram_addr_i  (dram_addr)
      ,.mem_addr_v_o (mem_addr_v)
      ,.mem_addr_o   (mem_addr)
      ,.mem_high_o   (mem_high)
      ,.event_i      (event_bits)
      ,.freeze_i     (freeze)
      ,.core_reset_o (core_reset)
      );

   initial
   begin
      aclk = 1'b0;
      forever #(clk_period_lp / 2) aclk = ~aclk;
   end

   // the polynomial x^16 + x^14 + x^13 + x^11 + 1 feeds each new bit in at the bottom
   function automatic logic [15:0] lfsr_step(input logic [15:0] s);
      return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
   endfunction

   // one LFSR step per bit taken and the first bit ends up most significant
   task automatic rand_bits(input int n, output logic [31:0] val);
      val = '0;
      for (int i = 0; i < n; i++)
      begin
         lfsr_q = lfsr_step(lfsr_q);
         val    = {val[30:0], lfsr_q[0]};
      end
   endtask

   task automatic stop_on_failure();
      verdict_printed = 1'b1;
      $display("CHECKS FAILED");
      $fatal(1);
   endtask

   task automatic check_value(input string name, input logic [63:0] expected,
                              input logic [63:0] actual);
      assert (actual === expected)
      else
      begin
         $display("FAILED %s expected %0h actual %0h", name, expected, actual);
         stop_on_failure();
      end
   endtask

   // the write lands on the second edge, so a read started next sees it
   task automatic write_reg(input logic [7:0] addr, input logic [31:0] data);
      @(posedge aclk);
      reg_wr    <= 1'b1;
      reg_addr  <= addr;
      reg_wdata <= data;
      @(posedge aclk);
      reg_wr    <= 1'b0;
   endtask

   // read data is due one cycle after the strobe and is sampled mid cycle
   task automatic expect_read(input string name, input logic [7:0] addr,
                              input logic [31:0] expected);
      @(posedge aclk);
      reg_rd   <= 1'b1;
      reg_addr <= addr;
      @(posedge aclk);
      reg_rd   <= 1'b0;
      @(negedge aclk);
      check_value({name, " valid"}, 1, reg_rdata_v);
      check_value(name, expected, reg_rdata);
   endtask

   initial
   begin
      #(watchdog_cycles_lp * clk_period_lp);
      $display("the tests did not finish within %0d cycles", watchdog_cycles_lp);
      stop_on_failure();
   end

   final
   begin
      if (!verdict_printed)
      begin
         $display("CHECKS FAILED");
      end
   end

   initial
   begin
      logic [31:0] r;
      logic [31:0] off;
      logic [31:0] exp_addr;
      logic        frz;
      int          freeze_left;

      lfsr_q        = 16'd59;
      profile_model = '0;
      frz           = 1'b0;
      freeze_left   = 0;
      for (int k = 0; k < num_counters_lp; k++)
      begin
         count_model[k] = '0;
      end
      reset      <= 1'b1;
      reg_wr     <= 1'b0;
      reg_rd     <= 1'b0;
      reg_addr   <= '0;
      reg_wdata  <= '0;
      ps_addr_v  <= 1'b0;
      ps_addr    <= '0;
      dram_req_v <= 1'b0;
      dram_addr  <= '0;
      event_bits <= '0;
      freeze     <= 1'b0;
      repeat (reset_cycles_lp) @(posedge aclk);
      reset <= 1'b0;
      @(negedge aclk);

      // control registers come up zero and the core stays in reset until run is set
      check_value("core reset after reset", 1, core_reset);
      expect_read("run after reset", 8'd0, 32'd0);
      expect_read("alloc after reset", 8'd1, 32'd0);
      expect_read("dram base after reset", 8'd2, 32'd0);
      write_reg(8'd0, 32'd1);
      @(negedge aclk);
      check_value("core reset released", 0, core_reset);
      rand_bits(32, r);
      write_reg(8'd1, r);
      rand_bits(32, base_model);
      write_reg(8'd2, base_model);
      expect_read("run readback", 8'd0, 32'd1);
      // only bit 0 of the alloc word is kept
      expect_read("alloc readback", 8'd1, {31'd0, r[0]});
      expect_read("dram base readback", 8'd2, base_model);
      expect_read("unmapped word 3", 8'd3, 32'd0);
      expect_read("unmapped word 200", 8'd200, 32'd0);

      // in the inbound window bit 31 is the inverse of bit 29 and bits 30 to 28 clear
      for (int i = 0; i < window_tests_lp; i++)
      begin
         rand_bits(30, r);
         exp_addr = (r & 32'h0FFF_FFFF) | (r[29] ? 32'h0 : 32'h8000_0000);
         @(posedge aclk);
         ps_addr_v <= 1'b1;
         ps_addr   <= r[29:0];
         @(posedge aclk);
         ps_addr_v <= 1'b0;
         @(negedge aclk);
         check_value("window valid", 1, core_addr_v);
         check_value("window translate", exp_addr, core_addr);
      end

      // short offsets mostly stay under the limit and wide ones mostly go above it
      for (int i = 0; i < dram_tests_lp; i++)
      begin
         rand_bits(1, r);
         if (r[0])
         begin
            rand_bits(30, off);
         end
         else
         begin
            rand_bits(27, off);
         end
         @(posedge aclk);
         dram_req_v <= 1'b1;
         dram_addr  <= off | 32'h8000_0000;
         profile_model[off[29:23]] = 1'b1;
         @(posedge aclk);
         dram_req_v <= 1'b0;
         @(negedge aclk);
         check_value("dram valid", 1, mem_addr_v);
         check_value("dram rebase", off + base_model, mem_addr);
         check_value("dram over limit", off >= mem_limit_lp, mem_high);
      end

      for (int w = 0; w < 4; w++)
      begin
         expect_read($sformatf("profile word %0d", w), 8'(4 + w), profile_model[32*w +: 32]);
      end
      // dropping run resets the core, which wipes the profiler bitmap
      write_reg(8'd0, 32'd0);
      @(negedge aclk);
      check_value("core reset on run clear", 1, core_reset);
      write_reg(8'd0, 32'd1);
      for (int w = 0; w < 4; w++)
      begin
         expect_read($sformatf("profile word %0d cleared", w), 8'(4 + w), 32'd0);
      end

      // events with random freeze stretches of 1 to 8 cycles
      for (int c = 0; c < event_cycles_lp; c++)
      begin
         if (freeze_left == 0)
         begin
            rand_bits(1, r);
            frz = r[0];
            rand_bits(3, off);
            freeze_left = int'(off[2:0]) + 1;
         end
         freeze_left--;
         rand_bits(num_counters_lp, r);
         @(posedge aclk);
         event_bits <= r[num_counters_lp-1:0];
         freeze     <= frz;
         for (int k = 0; k < num_counters_lp; k++)
         begin
            if (r[k] && !frz)
            begin
               count_model[k] = count_model[k] + 64'd1;
            end
         end
      end
      @(posedge aclk);
      event_bits <= '0;
      freeze     <= 1'b0;
      for (int k = 0; k < num_counters_lp; k++)
      begin
         expect_read($sformatf("counter %0d low", k), 8'(8 + 2 * k), count_model[k][31:0]);
         expect_read($sformatf("counter %0d high", k), 8'(9 + 2 * k), count_model[k][63:32]);
      end
      write_reg(8'd0, 32'd0);
      write_reg(8'd0, 32'd1);
      for (int k = 0; k < num_counters_lp; k++)
      begin
         expect_read($sformatf("counter %0d low cleared", k), 8'(8 + 2 * k), 32'd0);
         expect_read($sformatf("counter %0d high cleared", k), 8'(9 + 2 * k), 32'd0);
      end

      verdict_printed = 1'b1;
      $display("ALL CHECKS PASSED");
      $finish;
   end

endmodule

//--- verification/zynq_core_shell_props.sv
`timescale 1ns/1ps

module zynq_core_shell_props
   (input logic aclk_i
   ,input logic reset_i
   ,input logic reg_rd_i
   ,input logic reg_rdata_v_i
   ,input logic ps_addr_v_i
   ,input logic core_addr_v_i
   ,input logic dram_req_v_i
   ,input logic mem_addr_v_i
   ,input logic mem_high_i
   ,input logic run_i
   ,input logic core_reset_i
   );

   // every valid follows its strobe by exactly one cycle
   read_valid_timing: assert property (@(posedge aclk_i) disable iff (reset_i)
      reg_rdata_v_i == $past(reg_rd_i))
      else $error("read valid did not follow the read strobe by one cycle");

   window_valid_timing: assert property (@(posedge aclk_i) disable iff (reset_i)
      core_addr_v_i == $past(ps_addr_v_i))
      else $error("window valid did not follow the window request by one cycle");

   dram_valid_timing: assert property (@(posedge aclk_i) disable iff (reset_i)
      mem_addr_v_i == $past(dram_req_v_i))
      else $error("dram valid did not follow the dram request by one cycle");

   // the limit flag only rides on a valid rebased address
   high_needs_valid: assert property (@(posedge aclk_i) mem_high_i |-> mem_addr_v_i)
      else $error("over limit flag raised without a valid dram address");

   // a cycle spent in reset leaves every valid and the limit flag low
   quiet_after_reset: assert property (@(posedge aclk_i)
      $past(reset_i) |-> (!reg_rdata_v_i && !core_addr_v_i && !mem_addr_v_i && !mem_high_i))
      else $error("outputs were not low after reset");

   // core reset is pure logic of the system reset and the run bit
   core_reset_rule: assert property (@(posedge aclk_i) core_reset_i == (reset_i | ~run_i))
      else $error("core reset does not match system reset or cleared run bit");

endmodule

bind zynq_core_shell zynq_core_shell_props props_inst
   (.aclk_i       (aclk_i)
   ,.reset_i      (reset_i)
   ,.reg_rd_i     (reg_rd_i)
   ,.reg_rdata_v_i(reg_rdata_v_o)
   ,.ps_addr_v_i  (ps_addr_v_i)
   ,.core_addr_v_i(core_addr_v_o)
   ,.dram_req_v_i (dram_req_v_i)
   ,.mem_addr_v_i (mem_addr_v_o)
   ,.mem_high_i   (mem_high_o)
   ,.run_i        (run_lo)
   ,.core_reset_i (core_reset_o)
   );

//--- logic/zynq_core_shell.sv
`timescale 1ns/1ps

module zynq_core_shell
   #(parameter int                  num_counters_p = shell_pkg::default_num_counters_lp
   ,parameter shell_pkg::core_addr_t mem_limit_p   = shell_pkg::default_mem_limit_lp
   )
   (input  logic                                       aclk_i
   ,input  logic                                       reset_i

   // register bus from the PS
   ,input  logic                                       reg_wr_i
   ,input  logic                                       reg_rd_i
   ,input  logic [shell_pkg::reg_addr_width_lp-1:0]    reg_addr_i
   ,input  shell_pkg::reg_word_t                       reg_wdata_i
   ,output shell_pkg::reg_word_t                       reg_rdata_o
   ,output logic                                       reg_rdata_v_o

   // PS window into the core address space
   ,input  logic                                       ps_addr_v_i
   ,input  logic [shell_pkg::ps_addr_width_lp-1:0]     ps_addr_i
   ,output logic                                       core_addr_v_o
   ,output shell_pkg::core_addr_t                      core_addr_o

   // core DRAM requests toward the PS memory
   ,input  logic                                       dram_req_v_i
   ,input  shell_pkg::core_addr_t                      dram_addr_i
   ,output logic                                       mem_addr_v_o
   ,output shell_pkg::core_addr_t                      mem_addr_o
   ,output logic                                       mem_high_o

   // core event strobes and the core reset
   ,input  logic [num_counters_p-1:0]                  event_i
   ,input  logic                                       freeze_i
   ,output logic                                       core_reset_o
   );

   import shell_pkg::*;

   // control registers written by the PS
   logic       run_lo;
   logic       alloc_lo;
   reg_word_t  dram_base_lo;

   // full status vectors gathered for readback
   logic [profile_regions_lp-1:0]                  profile_lo;
   logic [num_counters_p-1:0][counter_width_lp-1:0] counts_lo;

   shell_csr_decode csr_decode_inst
      (.aclk_i      (aclk_i)
      ,.reset_i     (reset_i)
      ,.reg_wr_i    (reg_wr_i)
      ,.reg_addr_i  (reg_addr_i)
      ,.reg_wdata_i (reg_wdata_i)
      ,.run_o       (run_lo)
      ,.alloc_o     (alloc_lo)
      ,.dram_base_o (dram_base_lo)
      ,.core_reset_o(core_reset_o)
      );

   shell_addr_map #(.mem_limit_p(mem_limit_p)) addr_map_inst
      (.aclk_i       (aclk_i)
      ,.reset_i      (reset_i)
      ,.ps_addr_v_i  (ps_addr_v_i)
      ,.ps_addr_i    (ps_addr_i)
      ,.dram_req_v_i (dram_req_v_i)
      ,.dram_addr_i  (dram_addr_i)
      ,.dram_base_i  (dram_base_lo)
      ,.core_addr_v_o(core_addr_v_o)
      ,.core_addr_o  (core_addr_o)
      ,.mem_addr_v_o (mem_addr_v_o)
      ,.mem_addr_o   (mem_addr_o)
      ,.mem_high_o   (mem_high_o)
      );

   // counters and profiler live in the core reset domain
   stall_counter_bank #(.num_counters_p(num_counters_p)) counter_bank_inst
      (.aclk_i      (aclk_i)
      ,.core_reset_i(core_reset_o)
      ,.freeze_i    (freeze_i)
      ,.event_i     (event_i)
      ,.counts_o    (counts_lo)
      );

   mem_region_profiler profiler_inst
      (.aclk_i      (aclk_i)
      ,.core_reset_i(core_reset_o)
      ,.dram_req_v_i(dram_req_v_i)
      ,.dram_addr_i (dram_addr_i)
      ,.profile_o   (profile_lo)
      );

   csr_readback #(.num_counters_p(num_counters_p)) readback_inst
      (.aclk_i       (aclk_i)
      ,.reset_i      (reset_i)
      ,.reg_rd_i     (reg_rd_i)
      ,.reg_addr_i   (reg_addr_i)
      ,.run_i        (run_lo)
      ,.alloc_i      (alloc_lo)
      ,.dram_base_i  (dram_base_lo)
      ,.profile_i    (profile_lo)
      ,.counts_i     (counts_lo)
      ,.reg_rdata_o  (reg_rdata_o)
      ,.reg_rdata_v_o(reg_rdata_v_o)
      );

endmodule

//--- logic/csr_readback.sv
`timescale 1ns/1ps

module csr_readback
   #(parameter int num_counters_p = shell_pkg::default_num_counters_lp)
   (input  logic                                                  aclk_i
   ,input  logic                                                  reset_i
   ,input  logic                                                  reg_rd_i
   ,input  logic [shell_pkg::reg_addr_width_lp-1:0]               reg_addr_i
   ,input  logic                                                  run_i
   ,input  logic                                                  alloc_i
   ,input  shell_pkg::reg_word_t                                  dram_base_i
   ,input  logic [shell_pkg::profile_regions_lp-1:0]              profile_i
   ,input  logic [num_counters_p-1:0][shell_pkg::counter_width_lp-1:0] counts_i
   ,output shell_pkg::reg_word_t                                  reg_rdata_o
   ,output logic                                                  reg_rdata_v_o
   );

   import shell_pkg::*;

   // first index past the last counter high half
   localparam logic [reg_addr_width_lp-1:0] counter_end_lp =
      reg_addr_width_lp'(int'(counter_idx_lp) + 2 * num_counters_p);

   csr_region_e                         region;
   logic [$clog2(profile_words_lp)-1:0] profile_sel;
   logic [reg_addr_width_lp-1:0]        counter_off;
   reg_word_t                           ctrl_word;
   reg_word_t                           profile_word;
   reg_word_t                           counter_word;
   reg_word_t                           rdata_n;

   // the map is laid out in rising blocks, so ordered compares are enough
   always_comb
   begin
      if (reg_addr_i < profile_idx_lp)
         region = e_region_ctrl;
      else if (reg_addr_i < counter_idx_lp)
         region = e_region_profile;
      else if (reg_addr_i < counter_end_lp)
         region = e_region_counter;
      else
         region = e_region_none;
   end

   // control words, with index 3 left unmapped and read as zero
   always_comb
   begin
      case (reg_addr_i)
         run_idx_lp:       ctrl_word = reg_word_t'(run_i);
         alloc_idx_lp:     ctrl_word = reg_word_t'(alloc_i);
         dram_base_idx_lp: ctrl_word = dram_base_i;
         default:          ctrl_word = '0;
      endcase
   end

   // profiler words come out least significant first
   always_comb
   begin
      profile_sel  = $bits(profile_sel)'(reg_addr_i - profile_idx_lp);
      profile_word = profile_i[profile_sel * reg_width_lp +: reg_width_lp];
   end

   // offset bit 0 picks the half, the bits above it pick the counter
   always_comb
   begin
      counter_off  = reg_addr_i - counter_idx_lp;
      counter_word = '0;
      for (int k = 0; k < num_counters_p; k++)
      begin
         if (counter_off[reg_addr_width_lp-1:1] == (reg_addr_width_lp-1)'(k))
         begin
            counter_word = counter_off[0] ? counts_i[k][counter_width_lp-1 -: reg_width_lp]
                                          : counts_i[k][reg_width_lp-1:0];
         end
      end
   end

   always_comb
   begin
      case (region)
         e_region_ctrl:    rdata_n = ctrl_word;
         e_region_profile: rdata_n = profile_word;
         e_region_counter: rdata_n = counter_word;
         default:          rdata_n = '0;
      endcase
   end

   // the word is captured in the strobe cycle and returned on the next one
   always_ff @(posedge aclk_i)
   begin
      if (reset_i)
         reg_rdata_v_o <= 1'b0;
      else
         reg_rdata_v_o <= reg_rd_i;
   end

   always_ff @(posedge aclk_i)
   begin
      if (reg_rd_i)
      begin
         reg_rdata_o <= rdata_n;
      end
   end

endmodule

//--- logic/mem_region_profiler.sv
`timescale 1ns/1ps

module mem_region_profiler
   (input  logic                                 aclk_i
   ,input  logic                                 core_reset_i
   ,input  logic                                 dram_req_v_i
   ,input  shell_pkg::core_addr_t                dram_addr_i
   ,output logic [shell_pkg::profile_regions_lp-1:0] profile_o
   );

   import shell_pkg::*;

   // regions slice the 1 GiB window below bit 30 into equal parts
   localparam int region_width_lp = $clog2(profile_regions_lp);
   localparam int region_msb_lp   = 29;

   logic [region_width_lp-1:0]    region_idx;
   logic [profile_regions_lp-1:0] region_hit;
   logic [profile_regions_lp-1:0] profile_r;

   // one-hot of the region a valid request touches, zero when idle
   always_comb
   begin
      region_idx             = dram_addr_i[region_msb_lp -: region_width_lp];
      region_hit             = '0;
      region_hit[region_idx] = dram_req_v_i;
   end

   // bits are sticky until the core is reset, which shows how much memory a program used
   always_ff @(posedge aclk_i)
   begin
      if (core_reset_i)
      begin
         profile_r <= '0;
      end
      else
      begin
         profile_r <= profile_r | region_hit;
      end
   end

   assign profile_o = profile_r;

endmodule

//--- logic/stall_counter_bank.sv
`timescale 1ns/1ps

module stall_counter_bank
   #(parameter int num_counters_p = shell_pkg::default_num_counters_lp)
   (input  logic                                                  aclk_i
   ,input  logic                                                  core_reset_i
   ,input  logic                                                  freeze_i
   ,input  logic [num_counters_p-1:0]                             event_i
   ,output logic [num_counters_p-1:0][shell_pkg::counter_width_lp-1:0] counts_o
   );

   import shell_pkg::*;

   // a counter steps only while its event is high and the core is not frozen
   logic [num_counters_p-1:0]                   count_en;
   logic [num_counters_p-1:0][counter_width_lp-1:0] count_r;

   // freeze holds every counter at once, so a halted core leaves the counts stable
   always_comb
   begin
      count_en = event_i & {num_counters_p{~freeze_i}};
   end

   // 64 bits never wraps in any realistic run, so there is no saturation
   // core reset clears the bank so each program starts from zero
   always_ff @(posedge aclk_i)
   begin
      if (core_reset_i)
      begin
         count_r <= '0;
      end
      else
      begin
         for (int k = 0; k < num_counters_p; k++)
         begin
            if (count_en[k])
            begin
               count_r[k] <= count_r[k] + counter_width_lp'(1);
            end
         end
      end
   end

   // the readback path samples all counters, so the whole bank leaves as one vector
   assign counts_o = count_r;

endmodule

//--- logic/shell_addr_map.sv
`timescale 1ns/1ps

module shell_addr_map
   #(parameter shell_pkg::core_addr_t mem_limit_p = shell_pkg::default_mem_limit_lp)
   (input  logic                                   aclk_i
   ,input  logic                                   reset_i
   ,input  logic                                   ps_addr_v_i
   ,input  logic [shell_pkg::ps_addr_width_lp-1:0] ps_addr_i
   ,input  logic                                   dram_req_v_i
   ,input  shell_pkg::core_addr_t                  dram_addr_i
   ,input  shell_pkg::reg_word_t                   dram_base_i
   ,output logic                                   core_addr_v_o
   ,output shell_pkg::core_addr_t                  core_addr_o
   ,output logic                                   mem_addr_v_o
   ,output shell_pkg::core_addr_t                  mem_addr_o
   ,output logic                                   mem_high_o
   );

   import shell_pkg::*;

   core_addr_t core_addr_n;
   core_addr_t dram_offset;
   core_addr_t mem_addr_n;
   logic       mem_high_n;

   // inbound, window bit 29 picks between the two 256 MiB halves
   // window 0x0000_0000 lands on core DRAM at 0x8000_0000
   // window 0x2000_0000 lands on core local space at 0x0000_0000
   always_comb
   begin
      core_addr_n = {~ps_addr_i[ps_addr_width_lp-1], 3'b000, ps_addr_i[27:0]};
   end

   // outbound, strip the core DRAM base and add the buffer the PS allocated
   // the xor works as a subtract since core DRAM addresses all have bit 31 set
   always_comb
   begin
      dram_offset = dram_addr_i ^ dram_base_core_lp;
      mem_addr_n  = dram_offset + dram_base_i;
      mem_high_n  = dram_req_v_i & (dram_offset >= mem_limit_p);
   end

   // valids and the limit flag are control state
   always_ff @(posedge aclk_i)
   begin
      if (reset_i)
      begin
         core_addr_v_o <= 1'b0;
         mem_addr_v_o  <= 1'b0;
         mem_high_o    <= 1'b0;
      end
      else
      begin
         core_addr_v_o <= ps_addr_v_i;
         mem_addr_v_o  <= dram_req_v_i;
         mem_high_o    <= mem_high_n;
      end
   end

   // addresses follow their valids by exactly one cycle
   always_ff @(posedge aclk_i)
   begin
      core_addr_o <= core_addr_n;
      mem_addr_o  <= mem_addr_n;
   end

endmodule

//--- logic/shell_csr_decode.sv
`timescale 1ns/1ps

module shell_csr_decode
   (input  logic                                    aclk_i
   ,input  logic                                    reset_i
   ,input  logic                                    reg_wr_i
   ,input  logic [shell_pkg::reg_addr_width_lp-1:0] reg_addr_i
   ,input  shell_pkg::reg_word_t                    reg_wdata_i
   ,output logic                                    run_o
   ,output logic                                    alloc_o
   ,output shell_pkg::reg_word_t                    dram_base_o
   ,output logic                                    core_reset_o
   );

   import shell_pkg::*;

   // one write enable per PS-written register
   logic      run_we;
   logic      alloc_we;
   logic      dram_base_we;

   logic      run_r;
   logic      alloc_r;
   reg_word_t dram_base_r;

   // a write strobe hits at most one of the three control words
   always_comb
   begin
      run_we       = reg_wr_i & (reg_addr_i == run_idx_lp);
      alloc_we     = reg_wr_i & (reg_addr_i == alloc_idx_lp);
      dram_base_we = reg_wr_i & (reg_addr_i == dram_base_idx_lp);
   end

   // run and alloc keep only bit 0 of the written word
   // the DRAM base takes the whole word as the PS physical address of the buffer
   always_ff @(posedge aclk_i)
   begin
      if (reset_i)
      begin
         run_r       <= 1'b0;
         alloc_r     <= 1'b0;
         dram_base_r <= '0;
      end
      else
      begin
         if (run_we)
         begin
            run_r <= reg_wdata_i[0];
         end
         if (alloc_we)
         begin
            alloc_r <= reg_wdata_i[0];
         end
         if (dram_base_we)
         begin
            dram_base_r <= reg_wdata_i;
         end
      end
   end

   assign run_o       = run_r;
   assign alloc_o     = alloc_r;
   assign dram_base_o = dram_base_r;

   // the core is held in reset by the system reset or while the PS has not set run
   // clearing run lets software restart a program without reloading the bitstream
   assign core_reset_o = reset_i | ~run_r;

endmodule

//--- logic/shell_pkg.sv
package shell_pkg;

   // register bus seen by the PS, one 32-bit word per index
   localparam int reg_width_lp      = 32;
   localparam int reg_addr_width_lp = 8;

   // every event counter is a full 64-bit count read as two words
   localparam int counter_width_lp = 64;

   // the PS window port drops the top two address bits
   localparam int ps_addr_width_lp   = 30;
   localparam int core_addr_width_lp = 32;

   typedef logic [reg_width_lp-1:0]       reg_word_t;
   typedef logic [core_addr_width_lp-1:0] core_addr_t;

   // the core sees DRAM at 0x8000_0000, which is xor'ed away before rebasing
   localparam core_addr_t dram_base_core_lp = 32'h8000_0000;

   // anything at or above this offset is outside the memory given to the core
   localparam core_addr_t default_mem_limit_lp = 32'(241 * 1024 * 1024);

   // profiler bitmap, one bit per 8 MiB slice of the 1 GiB window
   localparam int profile_regions_lp = 128;
   localparam int profile_words_lp   = profile_regions_lp / reg_width_lp;

   localparam int default_num_counters_lp = 8;

   // fixed word indices of the register map
   localparam logic [reg_addr_width_lp-1:0] run_idx_lp       = 8'd0;
   localparam logic [reg_addr_width_lp-1:0] alloc_idx_lp     = 8'd1;
   localparam logic [reg_addr_width_lp-1:0] dram_base_idx_lp = 8'd2;
   // profiler words 4 to 7, least significant word first
   localparam logic [reg_addr_width_lp-1:0] profile_idx_lp   = 8'd4;
   // counter k sits at 8+2k (low half) and 9+2k (high half)
   localparam logic [reg_addr_width_lp-1:0] counter_idx_lp   = 8'd8;

   // which block answers a read, decoded from the word index
   typedef enum logic [1:0]
   {
      e_region_ctrl,
      e_region_profile,
      e_region_counter,
      e_region_none
   } csr_region_e;

endpackage
